// ==== verif/ex_vectors.txt ====
# op word ext src1 src2 expected_result expected_taken in hex
# op and ext codes match alu_op_e and ext_e
00 0 0 0000000000000005 0000000000000007 000000000000000c 0
00 0 0 ffffffffffffffff 0000000000000002 0000000000000001 0
00 1 0 000000007fffffff 0000000000000001 ffffffff80000000 0
01 0 0 0000000000000003 0000000000000005 fffffffffffffffe 0
01 1 0 0000000100000000 0000000000000001 ffffffffffffffff 0
02 0 0 f0f0f0f0f0f0f0f0 ff00ff00ff00ff00 f000f000f000f000 0
03 0 0 f0f0f0f0f0f0f0f0 0f0f0f0f0f0f0f0f ffffffffffffffff 0
04 0 0 123456789abcdef0 ffffffffffffffff edcba9876543210f 0
08 0 0 ffffffffffffffff 0000000000000001 0000000000000001 0
09 0 0 ffffffffffffffff 0000000000000001 0000000000000000 0
05 0 0 0000000000000001 000000000000003f 8000000000000000 0
05 0 0 0000000000000003 0000000000000041 0000000000000006 0
05 1 0 0000000000000001 000000000000003f ffffffff80000000 0
06 0 0 8000000000000000 000000000000003f 0000000000000001 0
06 1 0 ffffffff80000000 0000000000000004 0000000008000000 0
07 0 0 8000000000000000 0000000000000004 f800000000000000 0
07 1 0 00000000f0000000 0000000000000004 ffffffffff000000 0
0a 0 0 0000000000000010 0000000000000010 0000000000000000 1
0b 0 0 0000000000000010 0000000000000011 ffffffffffffffff 1
0c 0 0 8000000000000000 0000000000000001 7fffffffffffffff 1
0d 0 0 8000000000000000 0000000000000001 7fffffffffffffff 0
0e 0 0 8000000000000000 0000000000000001 7fffffffffffffff 0
0f 0 0 8000000000000000 0000000000000001 7fffffffffffffff 1
00 0 1 0000000080000000 0000000000000000 ffffffff80000000 0
00 0 2 ffffffff80000001 0000000000000000 0000000080000001 0
00 0 3 0000000000008000 0000000000000000 ffffffffffff8000 0
10 0 0 0000000000000007 0000000000000006 000000000000002a 0
10 0 0 fffffffffffffffd 0000000000000005 fffffffffffffff1 0
10 0 0 0000000100000001 0000000100000001 0000000200000001 0
10 1 1 0000000000010000 0000000000008000 ffffffff80000000 0

// ==== vlog.f ====
hdl/alu_pkg.sv
hdl/alu_comb.sv
hdl/mul_shift.sv
hdl/ex_result_mux.sv
hdl/ex_unit.sv
verif/ex_unit_chk.sv
verif/tb_ex_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the ex_unit testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -f vlog.f \
    --top-module tb_ex_unit -Mdir obj_dir -o sim_ex_unit
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_ex_unit +verilator+error+limit+10 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^PASS: all tests$" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

// ==== verif/tb_ex_unit.sv ====
`default_nettype none

module tb_ex_unit;
    timeunit 1ns;
    timeprecision 100ps;

    import alu_pkg::*;

    localparam int MAX_VEC = 64;
    localparam int TIMEOUT = 200;   // cycles allowed per mul

    logic    clk;
    logic    rst;
    logic    req_valid;
    ex_req_t req;
    logic    rsp_valid;
    ex_rsp_t rsp;
    logic    stall;

    ex_req_t         vec_req [MAX_VEC];
    logic [XLEN-1:0] vec_res [MAX_VEC];
    logic            vec_taken [MAX_VEC];
    int              num_vec;

    ex_unit #(
        .MUL_BITS (2)
    ) u_ex_unit (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .stall     (stall)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // bound checker failures end the run at once
    always @(negedge clk) begin
        if (u_ex_unit.u_ex_unit_chk.fail_count != 0) begin
            $display("assertion failure in the stall and valid checker");
            $display("FAIL: see errors above");
            $fatal(1, "assertion failed");
        end
    end

    task automatic check_val(input logic [XLEN-1:0] actual, input logic [XLEN-1:0] expected,
                             input string what);
        if (actual !== expected) begin
            $display("Fail at %0d ns: %s, got %h, expected %h", $time, what, actual, expected);
            $display("FAIL: see errors above");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic read_vectors();
        int              fd;
        int              n;
        string           line;
        logic [4:0]      op_v;
        logic            word_v;
        logic [1:0]      ext_v;
        logic [XLEN-1:0] s1;
        logic [XLEN-1:0] s2;
        logic [XLEN-1:0] res;
        logic            tk;
        num_vec = 0;
        fd = $fopen("verif/ex_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open verif/ex_vectors.txt");
            $display("FAIL: see errors above");
            $fatal(1, "no vector file");
        end
        while (!$feof(fd) && num_vec < MAX_VEC) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.getc(0) != "#") begin   // skip column notes
                n = $sscanf(line, "%h %h %h %h %h %h %h", op_v, word_v, ext_v, s1, s2, res, tk);
                if (n == 7) begin
                    vec_req[num_vec].op   = alu_op_e'(op_v);
                    vec_req[num_vec].word = word_v;
                    vec_req[num_vec].ext  = ext_e'(ext_v);
                    vec_req[num_vec].src1 = s1;
                    vec_req[num_vec].src2 = s2;
                    vec_res[num_vec]      = res;
                    vec_taken[num_vec]    = tk;
                    num_vec++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #2;
        req_valid = 1'b0;
        req       = '0;
        @(negedge clk);
        check_val(XLEN'(rsp_valid), '0, "rsp_valid while idle");
        check_val(XLEN'(stall), '0, "stall while idle");
    endtask

    task automatic run_vector(input int i);
        int cycles;
        @(posedge clk);
        #2;
        req_valid = 1'b1;
        req       = vec_req[i];
        @(negedge clk);
        if (vec_req[i].op != ALU_MUL) begin
            check_val(XLEN'(rsp_valid), XLEN'(1), $sformatf("rsp_valid, vector %0d", i));
            check_val(XLEN'(stall), '0, $sformatf("stall, vector %0d", i));
        end else begin
            check_val(XLEN'(stall), '0, "stall in mul start cycle");
            check_val(XLEN'(rsp_valid), '0, "rsp_valid in mul start cycle");
            cycles = 0;
            do begin   // request held until the done pulse
                @(negedge clk);
                cycles++;
                if (cycles > TIMEOUT) begin
                    $display("mul of vector %0d gave no response in %0d cycles", i, TIMEOUT);
                    $display("FAIL: see errors above");
                    $fatal(1, "timeout");
                end
                check_val(XLEN'(stall), XLEN'(1), $sformatf("stall in mul, vector %0d", i));
            end while (!rsp_valid);
        end
        check_val(rsp.result, vec_res[i], $sformatf("result, vector %0d", i));
        check_val(XLEN'(rsp.taken), XLEN'(vec_taken[i]), $sformatf("taken, vector %0d", i));
    endtask

    // reset lands while the multiplier is still stepping
    task automatic abort_mul(input int i);
        @(posedge clk);
        #2;
        req_valid = 1'b1;
        req       = vec_req[i];
        repeat (5) @(posedge clk);
        #2;
        check_val(XLEN'(stall), XLEN'(1), "stall before mid-mul reset");
        rst       = 1'b1;
        req_valid = 1'b0;
        @(posedge clk);
        #2;
        rst = 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_val(XLEN'(stall), '0, "stall after mid-mul reset");
            check_val(XLEN'(rsp_valid), '0, "rsp_valid after mid-mul reset");
        end
    endtask

    initial begin
        int gap;
        int last_mul;
        void'($urandom(8));
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        last_mul  = -1;
        read_vectors();
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        for (int i = 0; i < num_vec; i++) begin
            gap = int'($urandom_range(2, 0));   // random idle gap
            repeat (gap) idle_cycle();
            run_vector(i);
            if (vec_req[i].op == ALU_MUL)
                last_mul = i;
        end
        if (last_mul >= 0) begin
            abort_mul(last_mul);
            run_vector(0);
            run_vector(last_mul);
            idle_cycle();
        end
        if (last_mul < 0)
            $display("vector file holds no mul vector");
        if (u_ex_unit.u_ex_unit_chk.fail_count != 0)
            $display("%0d assertion failures", u_ex_unit.u_ex_unit_chk.fail_count);
        if (last_mul < 0 || u_ex_unit.u_ex_unit_chk.fail_count != 0) begin
            $display("FAIL: see errors above");
            $fatal(1, "run failed");
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== verif/ex_unit_chk.sv ====
`default_nettype none

module ex_unit_chk (
    input logic clk,
    input logic rst,
    input logic rsp_valid,
    input logic stall
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;   // read by the testbench at the end

    // multiplier comes out of reset idle
    a_no_stall_after_rst: assert property (@(posedge clk) rst |=> !stall)
        else begin
            fail_count++;
            $error("stall high in the cycle after reset");
        end

    // done is a single pulse
    a_one_mul_rsp: assert property (@(posedge clk) disable iff (rst)
        (stall && rsp_valid) |=> !(stall && rsp_valid))
        else begin
            fail_count++;
            $error("rsp_valid high for two cycles during a mul");
        end

    // stall only ends with the mul response, unless reset cut it short
    a_rsp_at_stall_end: assert property (@(posedge clk) disable iff (rst)
        ($fell(stall) && !$past(rst)) |-> $past(rsp_valid))
        else begin
            fail_count++;
            $error("stall fell without a mul response");
        end

endmodule

bind ex_unit ex_unit_chk u_ex_unit_chk (
    .clk       (clk),
    .rst       (rst),
    .rsp_valid (rsp_valid),
    .stall     (stall)
);

`default_nettype wire

// ==== hdl/ex_unit.sv ====
`default_nettype none

module ex_unit #(
    parameter int MUL_BITS = 1
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              req_valid,
    input  alu_pkg::ex_req_t  req,
    output logic              rsp_valid,
    output alu_pkg::ex_rsp_t  rsp,
    output logic              stall
);
    import alu_pkg::*;

    alu_out_t        alu_out;
    logic            mul_start;
    logic            mul_busy;
    logic            mul_done;
    logic [XLEN-1:0] product;

    // only start a mul when the multiplier is idle
    assign mul_start = req_valid && (req.op == ALU_MUL) && !mul_busy;

    alu_comb u_alu_comb (
        .req (req),
        .out (alu_out)
    );

    mul_shift #(
        .MUL_BITS (MUL_BITS)
    ) u_mul_shift (
        .clk     (clk),
        .rst     (rst),
        .start   (mul_start),
        .src1    (req.src1),
        .src2    (req.src2),
        .busy    (mul_busy),
        .done    (mul_done),
        .product (product)
    );

    ex_result_mux u_ex_result_mux (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req       (req),
        .alu       (alu_out),
        .mul_busy  (mul_busy),
        .mul_done  (mul_done),
        .product   (product),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .stall     (stall)
    );

endmodule

`default_nettype wire

// ==== hdl/ex_result_mux.sv ====
`default_nettype none

module ex_result_mux (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req_valid,
    input  alu_pkg::ex_req_t         req,
    input  alu_pkg::alu_out_t        alu,
    input  logic                     mul_busy,
    input  logic                     mul_done,
    input  logic [alu_pkg::XLEN-1:0] product,
    output logic                     rsp_valid,
    output alu_pkg::ex_rsp_t         rsp,
    output logic                     stall
);
    import alu_pkg::*;

    logic            mul_start;
    logic            mul_pend;    // a mul was started and not answered yet
    logic            pend_word;
    ext_e            pend_ext;
    logic            use_mul;
    logic [XLEN-1:0] mul_res;
    logic [XLEN-1:0] raw;
    ext_e            ext_sel;

    assign mul_start = req_valid && (req.op == ALU_MUL) && !mul_busy;

    always_ff @(posedge clk) begin
        if (rst)
            mul_pend <= 1'b0;
        else if (mul_start)
            mul_pend <= 1'b1;
        else if (mul_done)
            mul_pend <= 1'b0;
    end

    // word and ext of the mul, taken at the start edge
    always_ff @(posedge clk) begin
        if (mul_start) begin
            pend_word <= req.word;
            pend_ext  <= req.ext;
        end
    end

    assign use_mul = mul_done && mul_pend;
    assign mul_res = pend_word ? sext_word(product[WLEN-1:0]) : product;
    assign raw     = use_mul ? mul_res : alu.result;
    assign ext_sel = use_mul ? pend_ext : req.ext;

    always_comb begin
        case (ext_sel)
            EXT_SEXT32: rsp.result = sext_word(raw[WLEN-1:0]);
            EXT_ZEXT32: rsp.result = {{(XLEN - WLEN){1'b0}}, raw[WLEN-1:0]};
            EXT_SEXT16: rsp.result = {{(XLEN - 16){raw[15]}}, raw[15:0]};
            default:    rsp.result = raw;
        endcase
    end

    assign rsp.taken = alu.taken && !use_mul;   // mul never branches

    // one pulse per mul, same-cycle valid for everything else
    assign rsp_valid = use_mul || (req_valid && (req.op != ALU_MUL));
    assign stall     = mul_busy;                // through the done cycle

endmodule

`default_nettype wire

// ==== hdl/mul_shift.sv ====
`default_nettype none

module mul_shift #(
    parameter int MUL_BITS = 1   // multiplier bits retired per cycle
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,
    input  logic [alu_pkg::XLEN-1:0] src1,
    input  logic [alu_pkg::XLEN-1:0] src2,
    output logic                     busy,
    output logic                     done,
    output logic [alu_pkg::XLEN-1:0] product
);
    import alu_pkg::*;

    localparam int STEPS = XLEN / MUL_BITS;
    localparam int CNT_W = $clog2(STEPS + 1);

    if (XLEN % MUL_BITS != 0) begin : g_bad_mul_bits
        $error("mul_shift: MUL_BITS must divide the data width");
    end

    logic [XLEN-1:0]  mcand;    // shifted left each step
    logic [XLEN-1:0]  mplier;   // shifted right each step
    logic [XLEN-1:0]  acc;
    logic [XLEN-1:0]  step_sum;
    logic [CNT_W-1:0] cnt;
    logic             run;

    // busy also covers the done cycle, only the steps before it add
    assign run = busy && !done;

    always_comb begin
        step_sum = acc;
        for (int i = 0; i < MUL_BITS; i++) begin
            if (mplier[i])
                step_sum = step_sum + (mcand << i);   // low 64 bits only
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end else if (start && !busy) begin
            busy <= 1'b1;
            cnt  <= CNT_W'(STEPS);
        end else if (done) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else if (busy) begin
            cnt  <= cnt - CNT_W'(1);
            done <= (cnt == CNT_W'(1));   // last step
        end
    end

    always_ff @(posedge clk) begin
        if (start && !busy) begin
            mcand  <= src1;
            mplier <= src2;
            acc    <= '0;
        end else if (run) begin
            acc    <= step_sum;
            mcand  <= mcand << MUL_BITS;
            mplier <= mplier >> MUL_BITS;
        end
    end

    assign product = acc;

endmodule

`default_nettype wire

// ==== hdl/alu_comb.sv ====
`default_nettype none

module alu_comb (
    input  alu_pkg::ex_req_t  req,
    output alu_pkg::alu_out_t out
);
    import alu_pkg::*;

    logic [XLEN-1:0] src1;
    logic [XLEN-1:0] src2;
    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] diff;

    // shift amounts, 6 bits normally, 5 in word mode
    logic [5:0] shamt_d;
    logic [4:0] shamt_w;

    logic [XLEN-1:0] sll_d;
    logic [XLEN-1:0] srl_d;
    logic [XLEN-1:0] sra_d;
    logic [WLEN-1:0] sll_w;
    logic [WLEN-1:0] srl_w;
    logic [WLEN-1:0] sra_w;

    logic lt_s;
    logic lt_u;
    logic eq;

    assign src1 = req.src1;
    assign src2 = req.src2;

    assign sum  = src1 + src2;
    assign diff = src1 - src2;

    assign shamt_d = src2[5:0];
    assign shamt_w = src2[4:0];

    assign sll_d = src1 << shamt_d;
    assign srl_d = src1 >> shamt_d;
    assign sra_d = $signed(src1) >>> shamt_d;

    // word shifts only look at the low half of src1
    assign sll_w = src1[WLEN-1:0] << shamt_w;
    assign srl_w = src1[WLEN-1:0] >> shamt_w;
    assign sra_w = $signed(src1[WLEN-1:0]) >>> shamt_w;   // fills from bit 31

    assign lt_s = $signed(src1) < $signed(src2);
    assign lt_u = src1 < src2;
    assign eq   = (src1 == src2);

    always_comb begin
        out.result = diff;   // branch ops keep src1 - src2
        out.taken  = 1'b0;
        case (req.op)
            ALU_ADD: begin
                out.result = req.word ? sext_word(sum[WLEN-1:0]) : sum;
            end
            ALU_SUB: begin
                out.result = req.word ? sext_word(diff[WLEN-1:0]) : diff;
            end
            ALU_AND: out.result = src1 & src2;
            ALU_OR:  out.result = src1 | src2;
            ALU_XOR: out.result = src1 ^ src2;
            ALU_SLL: begin
                out.result = req.word ? sext_word(sll_w) : sll_d;
            end
            ALU_SRL: begin
                out.result = req.word ? sext_word(srl_w) : srl_d;
            end
            ALU_SRA: begin
                out.result = req.word ? sext_word(sra_w) : sra_d;
            end
            ALU_SLT:  out.result = {{(XLEN - 1){1'b0}}, lt_s};
            ALU_SLTU: out.result = {{(XLEN - 1){1'b0}}, lt_u};

            // compares, taken is the branch decision
            ALU_BEQ:  out.taken = eq;
            ALU_BNE:  out.taken = !eq;
            ALU_BLT:  out.taken = lt_s;
            ALU_BGE:  out.taken = !lt_s;
            ALU_BLTU: out.taken = lt_u;
            ALU_BGEU: out.taken = !lt_u;

            // mul result comes from the multiplier, nothing to do here
            default: begin
                out.result = diff;
                out.taken  = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/alu_pkg.sv ====
`default_nettype none

package alu_pkg;

    localparam int XLEN = 64;
    localparam int WLEN = 32;   // word half for the *w ops

    // encodings are what the vector file uses, keep them fixed
    typedef enum logic [4:0] {
        ALU_ADD  = 5'h00,
        ALU_SUB  = 5'h01,
        ALU_AND  = 5'h02,
        ALU_OR   = 5'h03,
        ALU_XOR  = 5'h04,
        ALU_SLL  = 5'h05,
        ALU_SRL  = 5'h06,
        ALU_SRA  = 5'h07,
        ALU_SLT  = 5'h08,
        ALU_SLTU = 5'h09,
        ALU_BEQ  = 5'h0a,
        ALU_BNE  = 5'h0b,
        ALU_BLT  = 5'h0c,
        ALU_BGE  = 5'h0d,
        ALU_BLTU = 5'h0e,
        ALU_BGEU = 5'h0f,
        ALU_MUL  = 5'h10
    } alu_op_e;

    typedef enum logic [1:0] {
        EXT_NONE   = 2'd0,
        EXT_SEXT32 = 2'd1,
        EXT_ZEXT32 = 2'd2,
        EXT_SEXT16 = 2'd3
    } ext_e;

    typedef struct packed {
        alu_op_e         op;
        logic            word;   // 32-bit op, result sign extended
        ext_e            ext;
        logic [XLEN-1:0] src1;
        logic [XLEN-1:0] src2;
    } ex_req_t;

    typedef struct packed {
        logic [XLEN-1:0] result;
        logic            taken;
    } ex_rsp_t;

    // raw alu side, before extension
    typedef struct packed {
        logic [XLEN-1:0] result;
        logic            taken;
    } alu_out_t;

    function automatic logic [XLEN-1:0] sext_word(input logic [WLEN-1:0] v);
        return {{(XLEN - WLEN){v[WLEN-1]}}, v};
    endfunction

endpackage

`default_nettype wire
